/* verilog/siso_pkg.sv */
package siso_pkg;

    // one soft metric, 16-bit two's complement, wraps on overflow
    typedef logic signed [15:0] metric_t;

    localparam int NUM_STATES = 8;

    // one metric per trellis state, index = state number
    typedef metric_t [NUM_STATES-1:0] state_vec_t;

    // everything the backward pass needs for one trellis step
    typedef struct packed {
        metric_t    gamma1;
        metric_t    gamma2;
        metric_t    sys;
        metric_t    apriori;
        state_vec_t alpha;
    } step_sample_t;

    // block-end metric of every state other than 0
    localparam metric_t NEG_INIT = -16'sd128;

    //////////////////////////////////////////////////////////////////////
    // trellis connectivity
    //////////////////////////////////////////////////////////////////////

    // per state: source of the +gamma branch and of the -gamma branch
    localparam logic [2:0] PLUS_SRC [NUM_STATES] = '{
        3'd0, 3'd4, 3'd5, 3'd1, 3'd2, 3'd6, 3'd7, 3'd3
    };
    localparam logic [2:0] MINUS_SRC [NUM_STATES] = '{
        3'd4, 3'd0, 3'd1, 3'd5, 3'd6, 3'd2, 3'd3, 3'd7
    };

    // states 2 to 5 use gamma2, the outer ones gamma1
    localparam bit G2_SEL [NUM_STATES] = '{
        1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0
    };

endpackage

/* verilog/input_buffer.sv */
`timescale 1ns/1ns

module input_buffer #(
    parameter int BLK_MAX = 64,
    localparam int IDX_W  = $clog2(BLK_MAX + 1),
    localparam int ADDR_W = $clog2(BLK_MAX)
) (
    input  logic                   clk,
    input  logic                   wr_en_i,
    input  logic [IDX_W-1:0]       wr_idx_i,
    input  siso_pkg::step_sample_t wr_step_i,
    input  logic [IDX_W-1:0]       rd_idx_i,
    output siso_pkg::step_sample_t rd_step_o
);

    // one row per trellis step of the block
    siso_pkg::step_sample_t mem [BLK_MAX];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_idx_i[ADDR_W-1:0]] <= wr_step_i;
        end
    end

    // registered read port
    always_ff @(posedge clk) begin
        rd_step_o <= mem[rd_idx_i[ADDR_W-1:0]];
    end

    // upper index bit is dropped above, so the writer must stay in range
    a_wr_idx: assert property (@(posedge clk)
        wr_en_i |-> (wr_idx_i < BLK_MAX))
        else $error("input buffer write index out of range");

endmodule

/* verilog/beta_recursion.sv */
`timescale 1ns/1ns

module beta_recursion #(
    parameter int BLK_MAX = 64,
    localparam int IDX_W  = $clog2(BLK_MAX + 1)
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   beta_init_i,
    input  logic [IDX_W-1:0]       init_idx_i,
    input  logic                   bwd_valid_i,
    input  logic [IDX_W-1:0]       bwd_idx_i,
    input  siso_pkg::step_sample_t step_i,
    input  logic [IDX_W-1:0]       beta_rd_idx_i,
    output siso_pkg::state_vec_t   beta_next_o
);

    siso_pkg::state_vec_t init_vec;
    siso_pkg::state_vec_t run_beta;
    siso_pkg::state_vec_t acs_vec;
    siso_pkg::state_vec_t norm_vec;

    // slots 0..blk_len, slot blk_len is the block end
    siso_pkg::state_vec_t beta_mem [BLK_MAX + 1];

    // block ends in state 0
    always_comb begin
        init_vec    = {siso_pkg::NUM_STATES{siso_pkg::NEG_INIT}};
        init_vec[0] = '0;
    end

    //////////////////////////////////////////////////////////////////////
    // add-compare-select, then normalize to state 0
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        siso_pkg::metric_t g;
        siso_pkg::metric_t up;
        siso_pkg::metric_t dn;
        for (int s = 0; s < siso_pkg::NUM_STATES; s++) begin
            g  = siso_pkg::G2_SEL[s] ? step_i.gamma2 : step_i.gamma1;
            up = run_beta[siso_pkg::PLUS_SRC[s]] + g;
            dn = run_beta[siso_pkg::MINUS_SRC[s]] - g;
            // ties go to the minus branch
            acs_vec[s] = (up > dn) ? up : dn;
        end
        for (int s = 0; s < siso_pkg::NUM_STATES; s++) begin
            norm_vec[s] = acs_vec[s] - acs_vec[0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst || beta_init_i) begin
            run_beta <= init_vec;
        end else if (bwd_valid_i) begin
            run_beta <= norm_vec;
        end
    end

    // single write port, init and recursion never share a cycle
    always_ff @(posedge clk) begin
        if (beta_init_i) begin
            beta_mem[init_idx_i] <= init_vec;
        end else if (bwd_valid_i) begin
            beta_mem[bwd_idx_i] <= norm_vec;
        end
    end

    always_ff @(posedge clk) begin
        beta_next_o <= beta_mem[beta_rd_idx_i];
    end

endmodule

/* verilog/llr_pipeline.sv */
`timescale 1ns/1ns

module llr_pipeline (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fwd_valid_i,
    input  siso_pkg::step_sample_t step_i,
    input  siso_pkg::state_vec_t   beta_next_i,
    output logic                   ext_valid_o,
    output siso_pkg::metric_t      ext_o
);

    siso_pkg::state_vec_t       set1_d;
    siso_pkg::state_vec_t       set2_d;
    siso_pkg::state_vec_t       set1_q;
    siso_pkg::state_vec_t       set2_q;
    siso_pkg::metric_t [3:0]    tree1_q;
    siso_pkg::metric_t [3:0]    tree2_q;
    siso_pkg::metric_t          max1_q;
    siso_pkg::metric_t          max2_q;
    siso_pkg::metric_t          sa1_q;
    siso_pkg::metric_t          sa2_q;
    siso_pkg::metric_t          sa3_q;
    siso_pkg::metric_t          llr;
    siso_pkg::metric_t          diff;
    siso_pkg::metric_t          ext_d;
    logic [2:0]                 vld_q;

    function automatic siso_pkg::metric_t smax(input siso_pkg::metric_t x,
                                               input siso_pkg::metric_t y);
        return (x > y) ? x : y;
    endfunction

    // stage 1 branch sums
    // set one follows the minus branches, set two the plus branches
    always_comb begin
        siso_pkg::metric_t g;
        for (int i = 0; i < siso_pkg::NUM_STATES; i++) begin
            g         = siso_pkg::G2_SEL[i] ? step_i.gamma2 : step_i.gamma1;
            set1_d[i] = step_i.alpha[i] - g + beta_next_i[siso_pkg::MINUS_SRC[i]];
            set2_d[i] = step_i.alpha[i] + g + beta_next_i[siso_pkg::PLUS_SRC[i]];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stage 4 output math
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        llr  = max1_q - max2_q;
        diff = llr - sa3_q;
        // about 0.75 of the difference
        ext_d = diff - (diff >>> 2);
    end

    always_ff @(posedge clk) begin
        set1_q <= set1_d;
        set2_q <= set2_d;
        sa1_q  <= step_i.sys + step_i.apriori;
        // stage 2 first tree level
        for (int i = 0; i < 4; i++) begin
            tree1_q[i] <= smax(set1_q[2*i], set1_q[2*i+1]);
            tree2_q[i] <= smax(set2_q[2*i], set2_q[2*i+1]);
        end
        sa2_q <= sa1_q;
        // stage 3 remaining two levels
        max1_q <= smax(smax(tree1_q[0], tree1_q[1]), smax(tree1_q[2], tree1_q[3]));
        max2_q <= smax(smax(tree2_q[0], tree2_q[1]), smax(tree2_q[2], tree2_q[3]));
        sa3_q  <= sa2_q;
        ext_o  <= ext_d;
    end

    // valid follows the data through all four stages
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q       <= '0;
            ext_valid_o <= 1'b0;
        end else begin
            vld_q       <= {vld_q[1:0], fwd_valid_i};
            ext_valid_o <= vld_q[2];
        end
    end

endmodule

/* verilog/siso_ctrl.sv */
`timescale 1ns/1ns

module siso_ctrl #(
    parameter int BLK_MAX = 64,
    localparam int IDX_W  = $clog2(BLK_MAX + 1)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             blk_start_i,
    input  logic [IDX_W-1:0] blk_len_i,
    input  logic             step_valid_i,
    output logic             wr_en_o,
    output logic [IDX_W-1:0] wr_idx_o,
    output logic [IDX_W-1:0] rd_idx_o,
    output logic             beta_init_o,
    output logic             bwd_valid_o,
    output logic [IDX_W-1:0] bwd_idx_o,
    output logic [IDX_W-1:0] beta_rd_idx_o,
    output logic             fwd_valid_o,
    output logic             busy_o
);

    typedef enum logic [1:0] {ST_IDLE, ST_LOAD, ST_BWD, ST_OUT} state_t;

    // read latency plus llr pipeline depth
    localparam logic [2:0] DRAIN_CYC = 3'd5;

    state_t           state;
    logic [IDX_W-1:0] cnt;
    logic [IDX_W-1:0] len_q;
    logic [2:0]       drain_q;
    logic             start_ok;
    logic             last_step;

    assign start_ok  = (state == ST_IDLE) && (drain_q == '0) && blk_start_i;
    assign last_step = (cnt == len_q - 1'b1);
    assign busy_o    = (state != ST_IDLE) || (drain_q != '0);

    assign wr_en_o       = (state == ST_LOAD) && step_valid_i;
    assign wr_idx_o      = cnt;
    assign beta_rd_idx_o = cnt + 1'b1;

    // backward phase counts blk_len down to 0 and the last cycle only waits on the read
    always_comb begin
        rd_idx_o = cnt;
        if (state == ST_BWD) begin
            rd_idx_o = cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_IDLE;
            cnt     <= '0;
            len_q   <= '0;
            drain_q <= '0;
        end else begin
            if (drain_q != '0) begin
                drain_q <= drain_q - 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    if (start_ok) begin
                        len_q <= blk_len_i;
                        cnt   <= '0;
                        state <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    if (step_valid_i && last_step) begin
                        cnt   <= len_q;
                        state <= ST_BWD;
                    end else if (step_valid_i) begin
                        cnt <= cnt + 1'b1;
                    end
                end
                ST_BWD: begin
                    if (cnt == '0) begin
                        state <= ST_OUT;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: begin
                    if (last_step) begin
                        drain_q <= DRAIN_CYC;
                        state   <= ST_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // strobes line up with the one-cycle read latency
    always_ff @(posedge clk) begin
        if (rst) begin
            beta_init_o <= 1'b0;
            bwd_valid_o <= 1'b0;
            fwd_valid_o <= 1'b0;
        end else begin
            beta_init_o <= wr_en_o && last_step;
            bwd_valid_o <= (state == ST_BWD) && (cnt != '0);
            fwd_valid_o <= (state == ST_OUT);
        end
    end

    always_ff @(posedge clk) begin
        bwd_idx_o <= cnt - 1'b1;
    end

    a_len_range: assert property (@(posedge clk) disable iff (rst)
        start_ok |-> (blk_len_i >= 1) && (blk_len_i <= BLK_MAX))
        else $error("block length out of range");

    a_wr_in_load: assert property (@(posedge clk) disable iff (rst)
        wr_en_o |-> (wr_idx_o < len_q))
        else $error("step write past the end of the block");

endmodule

/* verilog/siso_beta_top.sv */
`timescale 1ns/1ns

module siso_beta_top #(
    parameter int BLK_MAX = 64,
    localparam int IDX_W  = $clog2(BLK_MAX + 1)
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   blk_start_i,
    input  logic [IDX_W-1:0]       blk_len_i,
    input  logic                   step_valid_i,
    input  siso_pkg::step_sample_t step_i,
    output logic                   ext_valid_o,
    output siso_pkg::metric_t      ext_o,
    output logic                   busy_o
);

    logic                   wr_en;
    logic [IDX_W-1:0]       wr_idx;
    logic [IDX_W-1:0]       rd_idx;
    logic                   beta_init;
    logic                   bwd_valid;
    logic [IDX_W-1:0]       bwd_idx;
    logic [IDX_W-1:0]       beta_rd_idx;
    logic                   fwd_valid;
    siso_pkg::step_sample_t rd_step;
    siso_pkg::state_vec_t   beta_next;

    siso_ctrl #(.BLK_MAX(BLK_MAX)) u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .blk_start_i   (blk_start_i),
        .blk_len_i     (blk_len_i),
        .step_valid_i  (step_valid_i),
        .wr_en_o       (wr_en),
        .wr_idx_o      (wr_idx),
        .rd_idx_o      (rd_idx),
        .beta_init_o   (beta_init),
        .bwd_valid_o   (bwd_valid),
        .bwd_idx_o     (bwd_idx),
        .beta_rd_idx_o (beta_rd_idx),
        .fwd_valid_o   (fwd_valid),
        .busy_o        (busy_o)
    );

    input_buffer #(.BLK_MAX(BLK_MAX)) u_input_buffer (
        .clk       (clk),
        .wr_en_i   (wr_en),
        .wr_idx_i  (wr_idx),
        .wr_step_i (step_i),
        .rd_idx_i  (rd_idx),
        .rd_step_o (rd_step)
    );

    // step counter sits at blk_len while beta_init is high
    beta_recursion #(.BLK_MAX(BLK_MAX)) u_beta_recursion (
        .clk           (clk),
        .rst           (rst),
        .beta_init_i   (beta_init),
        .init_idx_i    (wr_idx),
        .bwd_valid_i   (bwd_valid),
        .bwd_idx_i     (bwd_idx),
        .step_i        (rd_step),
        .beta_rd_idx_i (beta_rd_idx),
        .beta_next_o   (beta_next)
    );

    llr_pipeline u_llr_pipeline (
        .clk         (clk),
        .rst         (rst),
        .fwd_valid_i (fwd_valid),
        .step_i      (rd_step),
        .beta_next_i (beta_next),
        .ext_valid_o (ext_valid_o),
        .ext_o       (ext_o)
    );

endmodule

/* test/tb_siso_model.svh */
`ifndef TB_SISO_MODEL_SVH
`define TB_SISO_MODEL_SVH

// larger of two wrapped metrics
function automatic siso_pkg::metric_t ref_max(input siso_pkg::metric_t x,
                                              input siso_pkg::metric_t y);
    return (x > y) ? x : y;
endfunction

// block end is known to be state 0
function automatic siso_pkg::state_vec_t end_vector();
    siso_pkg::state_vec_t v;
    for (int s = 0; s < siso_pkg::NUM_STATES; s++) begin
        v[s] = (s == 0) ? 16'sd0 : siso_pkg::NEG_INIT;
    end
    return v;
endfunction

// one backward step from beta k+1 to beta k, normalized to state 0
function automatic siso_pkg::state_vec_t next_beta(input siso_pkg::state_vec_t b,
                                                   input siso_pkg::metric_t g1,
                                                   input siso_pkg::metric_t g2);
    siso_pkg::state_vec_t n;
    siso_pkg::metric_t    n0;
    n[0] = ref_max(b[0] + g1, b[4] - g1);
    n[1] = ref_max(b[4] + g1, b[0] - g1);
    n[2] = ref_max(b[5] + g2, b[1] - g2);
    n[3] = ref_max(b[1] + g2, b[5] - g2);
    n[4] = ref_max(b[2] + g2, b[6] - g2);
    n[5] = ref_max(b[6] + g2, b[2] - g2);
    n[6] = ref_max(b[7] + g1, b[3] - g1);
    n[7] = ref_max(b[3] + g1, b[7] - g1);
    n0 = n[0];
    for (int s = 0; s < siso_pkg::NUM_STATES; s++) begin
        n[s] = n[s] - n0;
    end
    return n;
endfunction

// extrinsic of step k, b is the beta vector of step k+1
function automatic siso_pkg::metric_t ext_for_step(input siso_pkg::step_sample_t st,
                                                   input siso_pkg::state_vec_t b);
    siso_pkg::metric_t s1 [8];
    siso_pkg::metric_t s2 [8];
    siso_pkg::metric_t m1;
    siso_pkg::metric_t m2;
    siso_pkg::metric_t diff;
    s1[0] = st.alpha[0] - st.gamma1 + b[4];
    s1[1] = st.alpha[1] - st.gamma1 + b[0];
    s1[2] = st.alpha[2] - st.gamma2 + b[1];
    s1[3] = st.alpha[3] - st.gamma2 + b[5];
    s1[4] = st.alpha[4] - st.gamma2 + b[6];
    s1[5] = st.alpha[5] - st.gamma2 + b[2];
    s1[6] = st.alpha[6] - st.gamma1 + b[3];
    s1[7] = st.alpha[7] - st.gamma1 + b[7];
    s2[0] = st.alpha[0] + st.gamma1 + b[0];
    s2[1] = st.alpha[1] + st.gamma1 + b[4];
    s2[2] = st.alpha[2] + st.gamma2 + b[5];
    s2[3] = st.alpha[3] + st.gamma2 + b[1];
    s2[4] = st.alpha[4] + st.gamma2 + b[2];
    s2[5] = st.alpha[5] + st.gamma2 + b[6];
    s2[6] = st.alpha[6] + st.gamma1 + b[7];
    s2[7] = st.alpha[7] + st.gamma1 + b[3];
    m1 = s1[0];
    m2 = s2[0];
    for (int i = 1; i < 8; i++) begin
        m1 = ref_max(m1, s1[i]);
        m2 = ref_max(m2, s2[i]);
    end
    diff = (m1 - m2) - st.sys - st.apriori;
    return diff - (diff >>> 2);
endfunction

`endif

/* test/tb_siso_beta.sv */
`timescale 1ns/1ns

module tb_siso_beta;

    localparam int BLK_MAX    = 64;
    localparam int IDX_W      = $clog2(BLK_MAX + 1);
    localparam int TIMEOUT    = 1000;
    localparam int MODE_ZERO  = 0;
    localparam int MODE_SMALL = 1;
    localparam int MODE_FULL  = 2;
    localparam int NUM_ROWS   = 8;

    `include "tb_siso_model.svh"

    logic                   clk;
    logic                   rst;
    logic                   blk_start_i;
    logic [IDX_W-1:0]       blk_len_i;
    logic                   step_valid_i;
    siso_pkg::step_sample_t step_i;
    logic                   ext_valid_o;
    siso_pkg::metric_t      ext_o;
    logic                   busy_o;

    siso_pkg::step_sample_t blk      [BLK_MAX];
    siso_pkg::metric_t      exp_ext  [BLK_MAX];
    siso_pkg::state_vec_t   beta_ref [BLK_MAX + 1];

    //////////////////////////////////////////////////////////////////////
    // test table of name, block length, stimulus mode and junk flag
    //////////////////////////////////////////////////////////////////////

    string row_name [NUM_ROWS] = '{"all_zero", "small_len1", "small_len7", "full_max",
                                   "junk_small", "junk_full_max", "full_len7", "small_max"};
    int    row_len  [NUM_ROWS] = '{8, 1, 7, BLK_MAX, 16, BLK_MAX, 7, BLK_MAX};
    int    row_mode [NUM_ROWS] = '{MODE_ZERO, MODE_SMALL, MODE_SMALL, MODE_FULL,
                                   MODE_SMALL, MODE_FULL, MODE_FULL, MODE_SMALL};
    bit    row_junk [NUM_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0};

    siso_beta_top #(.BLK_MAX(BLK_MAX)) dut (
        .clk          (clk),
        .rst          (rst),
        .blk_start_i  (blk_start_i),
        .blk_len_i    (blk_len_i),
        .step_valid_i (step_valid_i),
        .step_i       (step_i),
        .ext_valid_o  (ext_valid_o),
        .ext_o        (ext_o),
        .busy_o       (busy_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string test_name, input int expected, input int actual);
        if (expected != actual) begin
            abort_run($sformatf("CHECK FAILED %s expected %0d actual %0d",
                                test_name, expected, actual));
        end
    endtask

    // inputs change and outputs are read 1 ns after the edge
    task automatic wait_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic siso_pkg::metric_t rand_metric(input int mode);
        case (mode)
            MODE_SMALL: return siso_pkg::metric_t'($urandom_range(63, 0)) - 16'sd32;
            MODE_FULL:  return siso_pkg::metric_t'($urandom);
            default:    return '0;
        endcase
    endfunction

    function automatic siso_pkg::step_sample_t make_step(input int mode);
        siso_pkg::step_sample_t st;
        st.gamma1  = rand_metric(mode);
        st.gamma2  = rand_metric(mode);
        st.sys     = rand_metric(mode);
        st.apriori = rand_metric(mode);
        for (int s = 0; s < siso_pkg::NUM_STATES; s++) begin
            st.alpha[s] = rand_metric(mode);
        end
        return st;
    endfunction

    task automatic build_expected(input int len);
        beta_ref[len] = end_vector();
        for (int k = len - 1; k >= 0; k--) begin
            beta_ref[k] = next_beta(beta_ref[k+1], blk[k].gamma1, blk[k].gamma2);
        end
        for (int k = 0; k < len; k++) begin
            exp_ext[k] = ext_for_step(blk[k], beta_ref[k+1]);
        end
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (busy_o) begin
            wait_cycle();
            waited++;
            if (waited > TIMEOUT) begin
                abort_run("timed out waiting for the DUT to become idle");
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // driver and collector of one block
    //////////////////////////////////////////////////////////////////////

    task automatic feed_block(input string name, input int len, input bit junk);
        int waited;
        blk_start_i = 1'b1;
        blk_len_i   = IDX_W'(len);
        wait_cycle();
        check_value($sformatf("%s busy after start", name), 1, int'(busy_o));
        // a start held high during load must be ignored
        blk_start_i = junk;
        for (int k = 0; k < len; k++) begin
            step_valid_i = 1'b1;
            step_i       = blk[k];
            wait_cycle();
        end
        step_valid_i = 1'b0;
        step_i       = '0;
        waited       = 0;
        while (junk && busy_o) begin
            blk_start_i  = 1'b1;
            blk_len_i    = IDX_W'($urandom_range(BLK_MAX, 1));
            step_valid_i = 1'b1;
            step_i       = make_step(MODE_FULL);
            wait_cycle();
            waited++;
            if (waited > TIMEOUT) begin
                abort_run("timed out driving junk while the DUT was busy");
            end
        end
        blk_start_i  = 1'b0;
        step_valid_i = 1'b0;
        step_i       = '0;
    endtask

    task automatic collect_outputs(input string name, input int len);
        int waited;
        waited = 0;
        while (!ext_valid_o) begin
            wait_cycle();
            waited++;
            if (waited > TIMEOUT) begin
                abort_run($sformatf("%s: no extrinsic output appeared in time", name));
            end
        end
        for (int k = 0; k < len; k++) begin
            check_value($sformatf("%s valid %0d", name, k), 1, int'(ext_valid_o));
            check_value($sformatf("%s step %0d", name, k), int'(exp_ext[k]), int'(ext_o));
            wait_cycle();
        end
        check_value($sformatf("%s output count", name), 0, int'(ext_valid_o));
        waited = 0;
        while (busy_o) begin
            wait_cycle();
            waited++;
            if (waited > TIMEOUT) begin
                abort_run($sformatf("%s: busy stayed high after the last output", name));
            end
        end
    endtask

    task automatic run_row(input int r);
        int len;
        len = row_len[r];
        for (int k = 0; k < len; k++) begin
            blk[k] = make_step(row_mode[r]);
        end
        build_expected(len);
        wait_idle();
        fork
            feed_block(row_name[r], len, row_junk[r]);
            collect_outputs(row_name[r], len);
        join
    endtask

    initial begin
        void'($urandom(85335));
        rst          = 1'b1;
        blk_start_i  = 1'b0;
        blk_len_i    = '0;
        step_valid_i = 1'b0;
        step_i       = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("after_reset busy", 0, int'(busy_o));
        check_value("after_reset valid", 0, int'(ext_valid_o));
        // rows follow each other with no idle gap
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

/* sources.f */
+incdir+test
verilog/siso_pkg.sv
verilog/input_buffer.sv
verilog/beta_recursion.sv
verilog/llr_pipeline.sv
verilog/siso_ctrl.sv
verilog/siso_beta_top.sv
test/tb_siso_beta.sv

/* Makefile */
TOP := tb_siso_beta

.PHONY: all run lint clean

all: run

obj_dir/sim: sources.f verilog/*.sv test/*.sv test/*.svh
	verilator --binary --timing -Wno-fatal -f sources.f --top-module $(TOP) -o sim

run: obj_dir/sim
	./obj_dir/sim | tee /dev/stderr | grep "Done: no errors" > /dev/null

lint:
	verilator --lint-only --timing -Wall -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir
